//--- source/ext_mem_pkg.sv
/*
 * Shared definitions for the external memory model on the conduit bus.
 * Holds the bus geometry, the memory depth, the read latency, the decoded
 * bus operation and the byte-lane mask helper. Referenced by scoped names.
 */

`default_nettype none

package ext_mem_pkg;

   // ----------------------------------------------------------------------
   // conduit geometry
   // ----------------------------------------------------------------------
   // byte address width
   localparam int addr_w = 8;
   // byte lanes per word and bits per lane
   localparam int symbols = 4;
   localparam int symbol_w = 8;
   localparam int data_w = symbols * symbol_w;

   // low address bits that select a byte inside a word
   localparam int lane_shift = 2;
   localparam int word_addr_w = addr_w - lane_shift;
   localparam int num_words = 2 ** word_addr_w;

   // cycles from accepted read to data on the bus, 1 to 8 supported
   localparam int read_latency = 2;

   // ----------------------------------------------------------------------
   // decoded operation of one bus cycle
   // ----------------------------------------------------------------------
   typedef enum logic [1:0] {
      op_idle  = 2'd0,
      op_read  = 2'd1,
      op_write = 2'd2
   } bus_op_t;

   // expand byte enables into a bit mask, one full lane per enable
   function automatic logic [data_w-1:0] lane_mask(input logic [symbols-1:0] be);
      logic [data_w-1:0] mask;
      mask = '0;
      for (int i = 0; i < symbols; i++) begin
         mask[i*symbol_w +: symbol_w] = {symbol_w{be[i]}};
      end
      return mask;
   endfunction

endpackage

`default_nettype wire

//--- source/ext_mem_core.sv
/*
 * Storage and strobe decode of the external memory model.
 * Turns the conduit strobes into one bus operation per clock, writes the
 * enabled byte lanes on the rising edge and presents the addressed word
 * combinationally for the read pipeline.
 */

`timescale 1ns/1ps
`default_nettype none

module ext_mem_core (
   input  logic                               clk,
   input  logic                               internal_reset,
   input  logic [ext_mem_pkg::addr_w-1:0]     address,
   input  logic [ext_mem_pkg::data_w-1:0]     write_data,
   input  logic [ext_mem_pkg::symbols-1:0]    byteenable,
   input  logic                               chipselect,
   input  logic                               read,
   input  logic                               write,
   input  logic                               outputenable,
   output logic                               read_accept,
   output logic [ext_mem_pkg::data_w-1:0]     read_word
);

   // decoded operation for this cycle
   ext_mem_pkg::bus_op_t bus_op;

   // word index into the array
   logic [ext_mem_pkg::word_addr_w-1:0] word_addr;

   // addressed word and its updated value
   logic [ext_mem_pkg::data_w-1:0] stored_word;
   logic [ext_mem_pkg::data_w-1:0] write_mask;
   logic [ext_mem_pkg::data_w-1:0] merged_word;

   // storage array
   logic [ext_mem_pkg::data_w-1:0] mem [ext_mem_pkg::num_words];

   // ----------------------------------------------------------------------
   // strobe decode
   // ----------------------------------------------------------------------
   always_comb begin
      // write wins when both strobes are up
      if (chipselect && write) begin
         bus_op = ext_mem_pkg::op_write;
      end
      // a read also needs the output enable
      else if (chipselect && read && outputenable) begin
         bus_op = ext_mem_pkg::op_read;
      end
      else begin
         bus_op = ext_mem_pkg::op_idle;
      end
   end

   // drop the byte select bits, so all lanes of a word share one entry
   assign word_addr = address[ext_mem_pkg::addr_w-1:ext_mem_pkg::lane_shift];

   // ----------------------------------------------------------------------
   // write path
   // ----------------------------------------------------------------------
   assign stored_word = mem[word_addr];
   assign write_mask  = ext_mem_pkg::lane_mask(byteenable);

   // keep disabled lanes, take enabled lanes from the bus
   assign merged_word = (stored_word & ~write_mask) | (write_data & write_mask);

   always_ff @(posedge clk or posedge internal_reset) begin
      if (internal_reset) begin
         // whole array reads back zero after reset
         for (int i = 0; i < ext_mem_pkg::num_words; i++) begin
            mem[i] <= '0;
         end
      end
      else if (bus_op == ext_mem_pkg::op_write) begin
         mem[word_addr] <= merged_word;
      end
   end

   // ----------------------------------------------------------------------
   // read path
   // ----------------------------------------------------------------------
   // accepted read goes to the latency pipe this cycle
   assign read_accept = (bus_op == ext_mem_pkg::op_read);

   // value before the edge, a write in the same cycle never coexists
   // with an accepted read
   assign read_word = stored_word;

endmodule

`default_nettype wire

//--- source/read_latency_pipe.sv
/*
 * Fixed read latency of the external memory model.
 * A shift register of drive flag and word per stage. Stage zero samples
 * the core every clock and the last stage drives the read data bus.
 */

`timescale 1ns/1ps
`default_nettype none

module read_latency_pipe (
   input  logic                               clk,
   input  logic                               internal_reset,
   input  logic                               read_accept,
   input  logic [ext_mem_pkg::data_w-1:0]     read_word,
   output logic [ext_mem_pkg::data_w-1:0]     read_data,
   output logic                               data_drive
);

   // per stage drive flag, one entry per cycle of latency
   logic drive_q [ext_mem_pkg::read_latency];

   // per stage captured word
   logic [ext_mem_pkg::data_w-1:0] word_q [ext_mem_pkg::read_latency];

   // ----------------------------------------------------------------------
   // drive flag chain
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or posedge internal_reset) begin
      if (internal_reset) begin
         for (int i = 0; i < ext_mem_pkg::read_latency; i++) begin
            drive_q[i] <= 1'b0;
         end
      end
      else begin
         // every cycle a new slot enters, idle cycles carry a low flag
         drive_q[0] <= read_accept;
         for (int i = 1; i < ext_mem_pkg::read_latency; i++) begin
            drive_q[i] <= drive_q[i-1];
         end
      end
   end

   // ----------------------------------------------------------------------
   // word chain
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or posedge internal_reset) begin
      if (internal_reset) begin
         for (int i = 0; i < ext_mem_pkg::read_latency; i++) begin
            word_q[i] <= '0;
         end
      end
      else begin
         word_q[0] <= read_word;
         // several reads can be in flight, one per stage
         for (int i = 1; i < ext_mem_pkg::read_latency; i++) begin
            word_q[i] <= word_q[i-1];
         end
      end
   end

   // ----------------------------------------------------------------------
   // output stage
   // ----------------------------------------------------------------------
   assign data_drive = drive_q[ext_mem_pkg::read_latency-1];

   // bus reads zero whenever the model is not driving
   assign read_data = data_drive ? word_q[ext_mem_pkg::read_latency-1] : '0;

endmodule

`default_nettype wire

//--- source/ext_mem_model.sv
/*
 * Top level of the external memory model on the conduit bus.
 * Connects the decode and storage core to the read latency pipeline.
 */

`timescale 1ns/1ps
`default_nettype none

module ext_mem_model (
   input  logic                               clk,
   input  logic                               internal_reset,
   input  logic [ext_mem_pkg::addr_w-1:0]     address,
   input  logic [ext_mem_pkg::data_w-1:0]     write_data,
   input  logic [ext_mem_pkg::symbols-1:0]    byteenable,
   input  logic                               chipselect,
   input  logic                               read,
   input  logic                               write,
   input  logic                               outputenable,
   output logic [ext_mem_pkg::data_w-1:0]     read_data,
   output logic                               data_drive
);

   // core to pipe, one accepted read per cycle at most
   logic                               read_accept;
   logic [ext_mem_pkg::data_w-1:0]     read_word;

   // ----------------------------------------------------------------------
   // decode and storage, zero latency
   // ----------------------------------------------------------------------
   ext_mem_core core0 (
      .clk            (clk),
      .internal_reset (internal_reset),
      .address        (address),
      .write_data     (write_data),
      .byteenable     (byteenable),
      .chipselect     (chipselect),
      .read           (read),
      .write          (write),
      .outputenable   (outputenable),
      .read_accept    (read_accept),
      .read_word      (read_word)
   );

   // ----------------------------------------------------------------------
   // read latency, read_latency cycles
   // ----------------------------------------------------------------------
   read_latency_pipe pipe0 (
      .clk            (clk),
      .internal_reset (internal_reset),
      .read_accept    (read_accept),
      .read_word      (read_word),
      .read_data      (read_data),
      .data_drive     (data_drive)
   );

endmodule

`default_nettype wire

//--- testbench/ext_mem_sva.sv
/*
 * Concurrent assertions on the strobe decode and the read pipeline timing
 * of the external memory model. Bound into the model top level by the
 * testbench, where both the core and the pipe outputs are visible.
 */

`timescale 1ns/1ps
`default_nettype none

module ext_mem_sva (
   input logic                              clk,
   input logic                              internal_reset,
   input logic                              write,
   input logic                              outputenable,
   input ext_mem_pkg::bus_op_t              bus_op,
   input logic                              read_accept,
   input logic                              data_drive
);

   // ----------------------------------------------------------------------
   // decode
   // ----------------------------------------------------------------------
   // write wins, so an accepted read never sees the write strobe
   a_read_without_write: assert property (@(posedge clk) disable iff (internal_reset)
      read_accept |-> !write)
      else $error("read accepted while the write strobe is high");

   // output enable gates every read
   a_read_needs_oe: assert property (@(posedge clk) disable iff (internal_reset)
      (bus_op == ext_mem_pkg::op_read) |-> outputenable)
      else $error("read operation decoded with output enable low");

   // ----------------------------------------------------------------------
   // pipeline timing
   // ----------------------------------------------------------------------
   // sampled values, the request cycle and the drive cycle lie
   // read_latency edges apart
   a_drive_after_latency: assert property (@(posedge clk) disable iff (internal_reset)
      $past(read_accept, ext_mem_pkg::read_latency) |-> data_drive)
      else $error("no drive flag read_latency cycles after an accepted read");

   // no drive cycle without a matching accepted read
   a_drive_only_after_read: assert property (@(posedge clk) disable iff (internal_reset)
      data_drive |-> $past(read_accept, ext_mem_pkg::read_latency))
      else $error("drive flag without an accepted read read_latency cycles earlier");

endmodule

`default_nettype wire

//--- testbench/ext_mem_tb.sv
/*
 * Testbench of the external memory model on the conduit bus.
 * Drives conduit cycles on the falling edge from a seeded generator, keeps
 * a word array and a queue of due reads as reference, and compares
 * data_drive and read_data with it in every cycle after reset.
 */

`timescale 1ns/1ps
`default_nettype none

module ext_mem_tb;

   // ----------------------------------------------------------------------
   // run length
   // ----------------------------------------------------------------------
   localparam int clk_period    = 8;
   localparam int reset_cycles  = 2;
   localparam int drain_cycles  = ext_mem_pkg::read_latency + 2;
   localparam int lanes         = 1 << ext_mem_pkg::lane_shift;
   localparam int mask_rounds   = 16;
   localparam int burst_reads   = 24;
   localparam int block_rounds  = 12;
   localparam int alias_rounds  = 16;
   localparam int random_cycles = 3000;
   // random traffic stays in the first few words to force reuse
   localparam int window_bytes  = 32;
   localparam int phase_cycles  = 2 * ext_mem_pkg::num_words + 4 * mask_rounds + burst_reads
                                  + 5 * block_rounds + 2 * alias_rounds + random_cycles;
   localparam int total_cycles  = reset_cycles + phase_cycles + 6 * drain_cycles;
   localparam int timeout_ns    = (total_cycles + 100) * clk_period;

   logic                                clk;
   logic                                internal_reset;
   logic [ext_mem_pkg::addr_w-1:0]      address;
   logic [ext_mem_pkg::data_w-1:0]      write_data;
   logic [ext_mem_pkg::symbols-1:0]     byteenable;
   logic                                chipselect;
   logic                                read;
   logic                                write;
   logic                                outputenable;
   logic [ext_mem_pkg::data_w-1:0]      read_data;
   logic                                data_drive;

   // reference model, words and reads waiting for their drive cycle
   logic [ext_mem_pkg::data_w-1:0]      model_mem [ext_mem_pkg::num_words];
   logic [ext_mem_pkg::data_w-1:0]      exp_word_q [$];
   int                                  exp_due_q [$];
   int                                  edge_count;
   int                                  model_index;
   int                                  write_count;
   int                                  checked_reads;

   ext_mem_model dut0 (
      .clk            (clk),
      .internal_reset (internal_reset),
      .address        (address),
      .write_data     (write_data),
      .byteenable     (byteenable),
      .chipselect     (chipselect),
      .read           (read),
      .write          (write),
      .outputenable   (outputenable),
      .read_data      (read_data),
      .data_drive     (data_drive)
   );

   // core decode and pipe flag are both reachable from the top
   bind ext_mem_model ext_mem_sva sva0 (
      .clk            (clk),
      .internal_reset (internal_reset),
      .write          (write),
      .outputenable   (outputenable),
      .bus_op         (core0.bus_op),
      .read_accept    (read_accept),
      .data_drive     (data_drive)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(clk_period / 2) clk = ~clk;
      end
   end

   // ----------------------------------------------------------------------
   // reference model, one decode per rising edge
   // ----------------------------------------------------------------------
   always @(posedge clk) begin
      if (internal_reset) begin
         edge_count = 0;
         write_count = 0;
         for (int i = 0; i < ext_mem_pkg::num_words; i++) begin
            model_mem[i] = '0;
         end
      end
      else begin
         edge_count = edge_count + 1;
         model_index = int'(address) >> ext_mem_pkg::lane_shift;
         if (chipselect && write) begin
            model_mem[model_index] = merge_bytes(model_mem[model_index], write_data, byteenable);
            write_count = write_count + 1;
         end
         else if (chipselect && read && outputenable) begin
            // request cycle is edge_count - 1, data read_latency cycles on
            exp_word_q.push_back(model_mem[model_index]);
            exp_due_q.push_back(edge_count - 1 + ext_mem_pkg::read_latency);
         end
      end
   end

   // watchdog sized from the cycle count of all phases
   initial begin
      #(timeout_ns);
      $display("simulation timed out after %0d ns", timeout_ns);
      stop_with_failure();
   end

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------
   function automatic logic [ext_mem_pkg::data_w-1:0] merge_bytes(
      input logic [ext_mem_pkg::data_w-1:0]  old_word,
      input logic [ext_mem_pkg::data_w-1:0]  new_word,
      input logic [ext_mem_pkg::symbols-1:0] be
   );
      logic [ext_mem_pkg::data_w-1:0] result;
      result = old_word;
      for (int i = 0; i < ext_mem_pkg::symbols; i++) begin
         if (be[i]) begin
            result[i*ext_mem_pkg::symbol_w +: ext_mem_pkg::symbol_w] =
               new_word[i*ext_mem_pkg::symbol_w +: ext_mem_pkg::symbol_w];
         end
      end
      return result;
   endfunction

   function automatic logic [ext_mem_pkg::addr_w-1:0] byte_address(input int word, input int lane);
      int a;
      a = word * lanes + lane;
      return a[ext_mem_pkg::addr_w-1:0];
   endfunction

   function automatic logic [ext_mem_pkg::addr_w-1:0] pick_address(input int span);
      int a;
      a = $urandom_range(span - 1, 0);
      return a[ext_mem_pkg::addr_w-1:0];
   endfunction

   function automatic logic [ext_mem_pkg::symbols-1:0] random_be();
      int unsigned r;
      r = $urandom;
      return r[ext_mem_pkg::symbols-1:0];
   endfunction

   // weighted coin, pct out of 100
   function automatic logic chance(input int unsigned pct);
      return $urandom_range(99, 0) < pct;
   endfunction

   function automatic logic [ext_mem_pkg::data_w-1:0] widen_flag(input logic flag);
      logic [ext_mem_pkg::data_w-1:0] w;
      w = '0;
      w[0] = flag;
      return w;
   endfunction

   task automatic stop_with_failure();
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic compare_value(input string name, input logic [ext_mem_pkg::data_w-1:0] actual,
                                input logic [ext_mem_pkg::data_w-1:0] expected);
      if (actual !== expected) begin
         $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
         stop_with_failure();
      end
   endtask

   // outputs are stable at the falling edge
   task automatic check_outputs();
      logic                           exp_drive;
      logic [ext_mem_pkg::data_w-1:0] exp_data;
      exp_drive = 1'b0;
      exp_data = '0;
      if (checked_reads < exp_word_q.size() && exp_due_q[checked_reads] == edge_count) begin
         exp_drive = 1'b1;
         exp_data = exp_word_q[checked_reads];
         checked_reads = checked_reads + 1;
      end
      compare_value("data_drive", widen_flag(data_drive), widen_flag(exp_drive));
      compare_value("read_data", read_data, exp_data);
   endtask

   // one conduit cycle, checked then driven on the falling edge
   task automatic bus_cycle(input logic [ext_mem_pkg::addr_w-1:0] addr,
                            input logic [ext_mem_pkg::data_w-1:0] wdata,
                            input logic [ext_mem_pkg::symbols-1:0] be,
                            input logic cs, input logic rd, input logic wr, input logic oe);
      @(negedge clk);
      check_outputs();
      address = addr;
      write_data = wdata;
      byteenable = be;
      chipselect = cs;
      read = rd;
      write = wr;
      outputenable = oe;
   endtask

   task automatic issue_read(input logic [ext_mem_pkg::addr_w-1:0] addr);
      bus_cycle(addr, '0, '0, 1'b1, 1'b1, 1'b0, 1'b1);
   endtask

   task automatic issue_write(input logic [ext_mem_pkg::addr_w-1:0] addr,
                              input logic [ext_mem_pkg::data_w-1:0] wdata,
                              input logic [ext_mem_pkg::symbols-1:0] be);
      bus_cycle(addr, wdata, be, 1'b1, 1'b0, 1'b1, 1'b0);
   endtask

   task automatic drain_pipeline();
      repeat (drain_cycles) begin
         bus_cycle('0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
      end
   endtask

   // ----------------------------------------------------------------------
   // phases
   // ----------------------------------------------------------------------
   // every word reads zero, idle cycles in between show no drive
   task automatic read_after_reset();
      for (int i = 0; i < ext_mem_pkg::num_words; i++) begin
         issue_read(byte_address(i, $urandom_range(lanes - 1, 0)));
         if (i % 2 == 0) begin
            bus_cycle('0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
         end
         else begin
            issue_read(pick_address(ext_mem_pkg::num_words * lanes));
         end
      end
      drain_pipeline();
   endtask

   // full write, partial write over it, read back the mixed word
   task automatic write_masked_lanes();
      logic [ext_mem_pkg::addr_w-1:0] addr;
      for (int i = 0; i < mask_rounds; i++) begin
         addr = byte_address($urandom_range(ext_mem_pkg::num_words - 1, 0), 0);
         issue_write(addr, $urandom, '1);
         issue_write(addr, $urandom, random_be());
         issue_read(addr);
         bus_cycle('0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
      end
      drain_pipeline();
   endtask

   // read_latency reads in flight at once
   task automatic read_back_to_back();
      for (int i = 0; i < burst_reads; i++) begin
         issue_read(pick_address(ext_mem_pkg::num_words * lanes));
      end
      drain_pipeline();
   endtask

   task automatic block_strobes();
      logic [ext_mem_pkg::addr_w-1:0] addr;
      for (int i = 0; i < block_rounds; i++) begin
         addr = byte_address($urandom_range(ext_mem_pkg::num_words - 1, 0), 0);
         // chip select low, neither write nor read lands
         bus_cycle(addr, $urandom, '1, 1'b0, 1'b0, 1'b1, 1'b0);
         bus_cycle(addr, '0, '0, 1'b0, 1'b1, 1'b0, 1'b1);
         // output enable low blocks the read
         bus_cycle(addr, '0, '0, 1'b1, 1'b1, 1'b0, 1'b0);
         // write and read together, write wins and no drive follows
         bus_cycle(addr, $urandom, random_be(), 1'b1, 1'b1, 1'b1, 1'b1);
         issue_read(addr);
      end
      drain_pipeline();
   endtask

   // low byte bits select no other word
   task automatic alias_low_bits();
      int word;
      int lane_a;
      int lane_b;
      for (int i = 0; i < alias_rounds; i++) begin
         word = $urandom_range(ext_mem_pkg::num_words - 1, 0);
         lane_a = $urandom_range(lanes - 1, 0);
         lane_b = (lane_a + 1 + $urandom_range(lanes - 2, 0)) % lanes;
         issue_write(byte_address(word, lane_a), $urandom, random_be());
         issue_read(byte_address(word, lane_b));
      end
      drain_pipeline();
   endtask

   task automatic mix_random_traffic();
      for (int i = 0; i < random_cycles; i++) begin
         bus_cycle(pick_address(window_bytes), $urandom, random_be(),
                   chance(85), chance(60), chance(30), chance(80));
      end
      drain_pipeline();
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial begin
      void'($urandom(35286));
      internal_reset = 1'b1;
      address = '0;
      write_data = '0;
      byteenable = '0;
      chipselect = 1'b0;
      read = 1'b0;
      write = 1'b0;
      outputenable = 1'b0;
      checked_reads = 0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      internal_reset = 1'b0;

      read_after_reset();
      write_masked_lanes();
      read_back_to_back();
      block_strobes();
      alias_low_bits();
      mix_random_traffic();

      $display("%0d reads and %0d writes compared", checked_reads, write_count);
      if (checked_reads != exp_word_q.size()) begin
         $display("%0d accepted reads never returned data", exp_word_q.size() - checked_reads);
         stop_with_failure();
      end
      else begin
         $display("Everything OK");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- flist.f
source/ext_mem_pkg.sv
source/ext_mem_core.sv
source/read_latency_pipe.sv
source/ext_mem_model.sv
testbench/ext_mem_sva.sv
testbench/ext_mem_tb.sv

//--- run.sh
#!/bin/sh
# Build the external memory model and its testbench with Verilator,
# run the simulation and decide pass or fail from the log.
set -e

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

rm -rf "$build_dir" "$log_file"

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module ext_mem_tb \
   --Mdir "$build_dir" -o ext_mem_sim \
   -f flist.f

# the simulator exits non-zero on a fatal error, the log decides
"$build_dir/ext_mem_sim" > "$log_file" 2>&1 || true
cat "$log_file"

if grep -q "Something failed" "$log_file"; then
   echo "simulation reported a failure"
   exit 1
fi
if ! grep -q "Everything OK" "$log_file"; then
   echo "simulation ended without reporting success"
   exit 1
fi
echo "simulation passed"
